// ==== rtl/cnn_macros.svh ====
`ifndef CNN_MACROS_SVH
`define CNN_MACROS_SVH

// Words per command, six 32-bit words give the 192-bit layout
`define CNN_CMD_WORDS 6
// Width of one command FIFO word
`define CNN_WORD_W 32
// Command count input and completion counter
`define CNN_CMD_CNT_W 7

// Opcode field at the bottom of the first word
`define CNN_OP_W 3
// Byte addresses for weights, samples and results
`define CNN_ADDR_W 32
// Signed sample and weight width
`define CNN_SAMPLE_W 8
// Window accumulator and final result widths
`define CNN_ACC_W 24
`define CNN_RES_W 16

`endif

// ==== rtl/cnn_pkg.sv ====
`include "cnn_macros.svh"

package cnn_pkg;

    // Operation codes carried in word 0 bits [2:0]
    typedef enum logic [`CNN_OP_W-1:0] {
        OP_IDLE      = 3'b000,
        OP_CONV_RELU = 3'b001,
        OP_MAX_POOL  = 3'b100,
        OP_AVG_POOL  = 3'b101
    } op_e;

    // Layer sequencer states
    typedef enum logic [2:0] {
        S_IDLE      = 3'd0,
        S_CMD_GET   = 3'd1,
        S_CMD_ISSUE = 3'd2,
        S_OP_RUN    = 3'd3,
        S_FINISH    = 3'd4
    } seq_state_e;

    // One decoded command, fields in FIFO word order
    typedef struct packed {
        op_e                    op;
        logic                   padding;
        logic [3:0]             stride;
        logic [7:0]             kernel;
        logic [15:0]            in_channel;
        logic [15:0]            out_channel;
        logic [7:0]             in_side;
        logic [7:0]             out_side;
        logic [`CNN_ADDR_W-1:0] weight_addr;
        logic [`CNN_ADDR_W-1:0] data_addr;
        logic [`CNN_ADDR_W-1:0] result_addr;
    } layer_cmd_t;

    // Raw window value handed from execute to result
    typedef struct packed {
        op_e                         op;
        logic signed [`CNN_ACC_W-1:0] acc;
        logic [7:0]                  kernel;
        logic [`CNN_ADDR_W-1:0]      result_addr;
    } engine_out_t;

    // Finalized output word and its write address
    typedef struct packed {
        logic signed [`CNN_RES_W-1:0] value;
        logic [`CNN_ADDR_W-1:0]       addr;
    } layer_result_t;

endpackage

// ==== rtl/cmd_decode.sv ====
`timescale 1ns/1ps
`include "cnn_macros.svh"

module cmd_decode (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      i_op_en,
    input  logic                      i_cmd_we,
    input  logic [`CNN_WORD_W-1:0]    i_cmd,
    input  logic [`CNN_CMD_CNT_W-1:0] i_cmd_count,
    input  logic                      i_engine_done,
    output logic                      o_cmd_rd_en,
    output cnn_pkg::layer_cmd_t       o_cmd,
    output logic                      o_engine_valid,
    output logic                      o_engine_clr,
    output logic                      o_irq
);

    localparam int WC_W = $clog2(`CNN_CMD_WORDS);

    cnn_pkg::seq_state_e       state;
    cnn_pkg::seq_state_e       next_state;
    logic [WC_W-1:0]           word_cnt;
    logic                      word_take;
    logic                      word_last;
    logic                      idle_done;
    logic                      op_done;
    logic [`CNN_CMD_CNT_W-1:0] done_cnt;
    logic [`CNN_CMD_CNT_W-1:0] done_next;

    // A FIFO word is consumed when the strobe meets the read level
    assign word_take = i_cmd_we && o_cmd_rd_en;
    assign word_last = (word_cnt == WC_W'(`CNN_CMD_WORDS - 1));
    // Completion comes from the engine, or from the local idle retire
    assign op_done   = (state == cnn_pkg::S_OP_RUN) && (i_engine_done || idle_done);
    assign done_next = done_cnt + 1'b1;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state <= cnn_pkg::S_IDLE;
        end else begin
            state <= next_state;
        end
    end

    always_comb begin
        next_state = state;
        case (state)
            cnn_pkg::S_IDLE: begin
                // Empty layer goes straight to the interrupt
                if (i_op_en) begin
                    next_state = (i_cmd_count == '0) ? cnn_pkg::S_FINISH : cnn_pkg::S_CMD_GET;
                end
            end
            cnn_pkg::S_CMD_GET: begin
                if (word_take && word_last) begin
                    next_state = cnn_pkg::S_CMD_ISSUE;
                end
            end
            cnn_pkg::S_CMD_ISSUE: begin
                next_state = cnn_pkg::S_OP_RUN;
            end
            cnn_pkg::S_OP_RUN: begin
                if (op_done) begin
                    next_state = (done_next == i_cmd_count) ? cnn_pkg::S_FINISH
                                                            : cnn_pkg::S_CMD_GET;
                end
            end
            cnn_pkg::S_FINISH: begin
                // Parked until reset
                next_state = cnn_pkg::S_FINISH;
            end
            default: begin
                next_state = cnn_pkg::S_IDLE;
            end
        endcase
    end

    // Split the six words into command fields
    always_ff @(posedge clk) begin
        if (word_take) begin
            case (word_cnt)
                0: begin
                    o_cmd.op      <= cnn_pkg::op_e'(i_cmd[2:0]);
                    o_cmd.padding <= i_cmd[4];
                    o_cmd.stride  <= i_cmd[11:8];
                    o_cmd.kernel  <= i_cmd[23:16];
                end
                1: begin
                    o_cmd.in_channel  <= i_cmd[15:0];
                    o_cmd.out_channel <= i_cmd[31:16];
                end
                2: begin
                    o_cmd.in_side  <= i_cmd[7:0];
                    o_cmd.out_side <= i_cmd[15:8];
                end
                3: o_cmd.weight_addr <= i_cmd;
                4: o_cmd.data_addr   <= i_cmd;
                5: o_cmd.result_addr <= i_cmd;
                default: ;
            endcase
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            word_cnt       <= '0;
            o_cmd_rd_en    <= 1'b0;
            o_engine_valid <= 1'b0;
            o_engine_clr   <= 1'b1;
            idle_done      <= 1'b0;
            done_cnt       <= '0;
            o_irq          <= 1'b0;
        end else begin
            // Read level follows the collect state, dropping with the last word
            o_cmd_rd_en <= (next_state == cnn_pkg::S_CMD_GET);
            if (next_state == cnn_pkg::S_FINISH) begin
                o_irq <= 1'b1;
            end
            case (state)
                cnn_pkg::S_CMD_GET: begin
                    o_engine_clr <= 1'b1;
                    if (word_take) begin
                        word_cnt <= word_last ? '0 : word_cnt + 1'b1;
                    end
                end
                cnn_pkg::S_CMD_ISSUE: begin
                    o_engine_clr <= 1'b0;
                    // Idle commands never reach the engine
                    if (o_cmd.op == cnn_pkg::OP_IDLE) begin
                        idle_done <= 1'b1;
                    end else begin
                        o_engine_valid <= 1'b1;
                    end
                end
                cnn_pkg::S_OP_RUN: begin
                    if (op_done) begin
                        o_engine_valid <= 1'b0;
                        idle_done      <= 1'b0;
                        done_cnt       <= done_next;
                    end
                end
                default: ;
            endcase
        end
    end

    // FIFO words only land while collecting
    a_word_in_get: assert property (@(posedge clk) disable iff (rst)
        word_take |-> state == cnn_pkg::S_CMD_GET);

    // The engine is never started for a no-op
    a_no_idle_issue: assert property (@(posedge clk) disable iff (rst)
        $rose(o_engine_valid) |-> o_cmd.op != cnn_pkg::OP_IDLE);

endmodule

// ==== rtl/window_engine.sv ====
`timescale 1ns/1ps
`include "cnn_macros.svh"

module window_engine (
    input  logic                           clk,
    input  logic                           rst,
    input  logic                           i_clr,
    input  logic                           i_start,
    input  cnn_pkg::layer_cmd_t            i_cmd,
    input  logic                           i_sample_we,
    input  logic signed [`CNN_SAMPLE_W-1:0] i_sample,
    input  logic signed [`CNN_SAMPLE_W-1:0] i_weight,
    output logic                           o_busy,
    output logic [`CNN_ADDR_W-1:0]         o_data_addr,
    output logic [`CNN_ADDR_W-1:0]         o_weight_addr,
    output logic                           o_done,
    output cnn_pkg::engine_out_t           o_out,
    output logic                           o_out_valid
);

    logic                          start_q;
    logic                          start_rise;
    logic                          first;
    logic [15:0]                   idx;
    logic [15:0]                   idx_next;
    logic [15:0]                   win_size;
    logic                          win_last;
    logic signed [`CNN_ACC_W-1:0]  acc;
    logic signed [`CNN_ACC_W-1:0]  acc_next;
    logic signed [`CNN_ACC_W-1:0]  sample_ext;
    logic signed [`CNN_ACC_W-1:0]  product;

    // Engine-valid is a level, so the command starts on its edge
    assign start_rise = i_start && !start_q;
    assign idx_next   = idx + 1'b1;
    assign win_last   = (idx_next == win_size);

    // Window addresses are linear offsets from the command bases
    assign o_data_addr   = i_cmd.data_addr + `CNN_ADDR_W'(idx);
    assign o_weight_addr = i_cmd.weight_addr + `CNN_ADDR_W'(idx);

    assign sample_ext = `CNN_ACC_W'(i_sample);
    assign product    = `CNN_ACC_W'(i_sample * i_weight);

    always_comb begin
        case (i_cmd.op)
            cnn_pkg::OP_CONV_RELU: acc_next = acc + product;
            cnn_pkg::OP_AVG_POOL:  acc_next = acc + sample_ext;
            // First sample seeds the max so all-negative windows work
            cnn_pkg::OP_MAX_POOL:  acc_next = (first || sample_ext > acc) ? sample_ext : acc;
            default:               acc_next = acc;
        endcase
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            start_q     <= 1'b0;
            o_busy      <= 1'b0;
            first       <= 1'b0;
            idx         <= '0;
            o_done      <= 1'b0;
            o_out_valid <= 1'b0;
        end else if (i_clr) begin
            start_q     <= 1'b0;
            o_busy      <= 1'b0;
            first       <= 1'b0;
            idx         <= '0;
            o_done      <= 1'b0;
            o_out_valid <= 1'b0;
        end else begin
            start_q     <= i_start;
            o_done      <= 1'b0;
            o_out_valid <= 1'b0;
            if (start_rise) begin
                o_busy <= 1'b1;
                first  <= 1'b1;
                idx    <= '0;
            end else if (o_busy && i_sample_we) begin
                first <= 1'b0;
                idx   <= idx_next;
                // Last sample of the window ends the run
                if (win_last) begin
                    o_busy      <= 1'b0;
                    o_done      <= 1'b1;
                    o_out_valid <= 1'b1;
                end
            end
        end
    end

    // Accumulator and output word
    always_ff @(posedge clk) begin
        if (start_rise) begin
            win_size <= 16'(i_cmd.kernel * i_cmd.kernel);
            acc      <= '0;
        end else if (o_busy && i_sample_we) begin
            acc <= acc_next;
            if (win_last) begin
                o_out.op          <= i_cmd.op;
                o_out.acc         <= acc_next;
                o_out.kernel      <= i_cmd.kernel;
                o_out.result_addr <= i_cmd.result_addr;
            end
        end
    end

    // Sample memory only answers a running window
    a_sample_when_busy: assert property (@(posedge clk) disable iff (rst)
        i_sample_we |-> o_busy);

endmodule

// ==== rtl/result_writer.sv ====
`timescale 1ns/1ps
`include "cnn_macros.svh"

module result_writer (
    input  logic                   clk,
    input  logic                   rst,
    input  cnn_pkg::engine_out_t   i_in,
    input  logic                   i_in_valid,
    output cnn_pkg::layer_result_t o_result,
    output logic                   o_result_valid
);

    localparam logic signed [`CNN_ACC_W-1:0] RES_MAX = (2 ** (`CNN_RES_W - 1)) - 1;
    localparam logic signed [`CNN_ACC_W-1:0] RES_MIN = -(2 ** (`CNN_RES_W - 1));

    logic signed [`CNN_ACC_W-1:0] acc_in;
    logic signed [`CNN_ACC_W-1:0] fin;
    logic signed [`CNN_RES_W-1:0] sat;

    assign acc_in = i_in.acc;

    always_comb begin
        case (i_in.op)
            // ReLU
            cnn_pkg::OP_CONV_RELU: fin = (acc_in < 0) ? '0 : acc_in;
            // Divide by kernel squared, only powers of two supported
            cnn_pkg::OP_AVG_POOL: begin
                case (i_in.kernel)
                    8'd2:    fin = acc_in >>> 2;
                    8'd4:    fin = acc_in >>> 4;
                    default: fin = acc_in;
                endcase
            end
            default: fin = acc_in;
        endcase
    end

    // Clip to the signed result range
    always_comb begin
        if (fin > RES_MAX) begin
            sat = RES_MAX[`CNN_RES_W-1:0];
        end else if (fin < RES_MIN) begin
            sat = RES_MIN[`CNN_RES_W-1:0];
        end else begin
            sat = fin[`CNN_RES_W-1:0];
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            o_result_valid <= 1'b0;
        end else begin
            o_result_valid <= i_in_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (i_in_valid) begin
            o_result.value <= sat;
            o_result.addr  <= i_in.result_addr;
        end
    end

    // Each command yields a single pulse, never back to back
    a_valid_pulse: assert property (@(posedge clk) disable iff (rst)
        o_result_valid |=> !o_result_valid);

endmodule

// ==== rtl/cnn_layer_top.sv ====
`timescale 1ns/1ps
`include "cnn_macros.svh"

module cnn_layer_top (
    input  logic                            clk,
    input  logic                            rst,
    input  logic                            i_op_en,
    input  logic                            i_cmd_we,
    input  logic [`CNN_WORD_W-1:0]          i_cmd,
    input  logic [`CNN_CMD_CNT_W-1:0]       i_cmd_count,
    input  logic                            i_sample_we,
    input  logic signed [`CNN_SAMPLE_W-1:0] i_sample,
    input  logic signed [`CNN_SAMPLE_W-1:0] i_weight,
    output logic                            o_cmd_rd_en,
    output logic [`CNN_ADDR_W-1:0]          o_data_addr,
    output logic [`CNN_ADDR_W-1:0]          o_weight_addr,
    output cnn_pkg::layer_result_t          o_result,
    output logic                            o_result_valid,
    output logic                            o_irq
);

    // Decode to execute
    cnn_pkg::layer_cmd_t  cmd;
    logic                 engine_valid;
    logic                 engine_clr;
    logic                 engine_done;
    // Execute to result
    cnn_pkg::engine_out_t engine_out;
    logic                 engine_out_valid;

    cmd_decode cmd_decode_i (
        .clk            (clk),
        .rst            (rst),
        .i_op_en        (i_op_en),
        .i_cmd_we       (i_cmd_we),
        .i_cmd          (i_cmd),
        .i_cmd_count    (i_cmd_count),
        .i_engine_done  (engine_done),
        .o_cmd_rd_en    (o_cmd_rd_en),
        .o_cmd          (cmd),
        .o_engine_valid (engine_valid),
        .o_engine_clr   (engine_clr),
        .o_irq          (o_irq)
    );

    // Busy only matters inside the engine
    window_engine window_engine_i (
        .clk           (clk),
        .rst           (rst),
        .i_clr         (engine_clr),
        .i_start       (engine_valid),
        .i_cmd         (cmd),
        .i_sample_we   (i_sample_we),
        .i_sample      (i_sample),
        .i_weight      (i_weight),
        .o_busy        (),
        .o_data_addr   (o_data_addr),
        .o_weight_addr (o_weight_addr),
        .o_done        (engine_done),
        .o_out         (engine_out),
        .o_out_valid   (engine_out_valid)
    );

    result_writer result_writer_i (
        .clk            (clk),
        .rst            (rst),
        .i_in           (engine_out),
        .i_in_valid     (engine_out_valid),
        .o_result       (o_result),
        .o_result_valid (o_result_valid)
    );

endmodule

// ==== sim/tb_cnn_layer.sv ====
`timescale 1ns/1ps
`include "cnn_macros.svh"

module tb_cnn_layer;

    localparam int CLK_HALF  = 20;
    localparam int MEM_DEPTH = 1024;
    // Directed windows live above the random address range
    localparam int SAT_BASE  = 992;
    localparam int NEG_BASE  = 1008;
    localparam int DIR_CMDS  = 9;
    localparam int RAND_CMDS = 12;
    // Words, a full 4x4 window and pipeline slack per command, four times over
    localparam int CMD_CYCLES   = (`CNN_CMD_WORDS + 16 + 10) * 4;
    localparam int SLACK_CYCLES = 100;

    logic                            clk;
    logic                            rst;
    logic                            i_op_en;
    logic                            i_cmd_we;
    logic [`CNN_WORD_W-1:0]          i_cmd;
    logic [`CNN_CMD_CNT_W-1:0]       i_cmd_count;
    logic                            i_sample_we;
    logic signed [`CNN_SAMPLE_W-1:0] i_sample;
    logic signed [`CNN_SAMPLE_W-1:0] i_weight;
    logic                            o_cmd_rd_en;
    logic [`CNN_ADDR_W-1:0]          o_data_addr;
    logic [`CNN_ADDR_W-1:0]          o_weight_addr;
    cnn_pkg::layer_result_t          o_result;
    logic                            o_result_valid;
    logic                            o_irq;

    // Sample and weight memory model
    logic signed [`CNN_SAMPLE_W-1:0] sample_mem [MEM_DEPTH];
    logic signed [`CNN_SAMPLE_W-1:0] weight_mem [MEM_DEPTH];
    logic [31:0]                     lcg_state;
    cnn_pkg::layer_cmd_t             layer_q [$];
    cnn_pkg::layer_result_t          exp_q [$];
    // Marks the result that should arrive together with the interrupt
    bit                              exp_last_q [$];
    int                              check_cnt;
    int                              mismatch_cnt;
    int                              error_cnt;

    cnn_layer_top cnn_layer_top_i (
        .clk            (clk),
        .rst            (rst),
        .i_op_en        (i_op_en),
        .i_cmd_we       (i_cmd_we),
        .i_cmd          (i_cmd),
        .i_cmd_count    (i_cmd_count),
        .i_sample_we    (i_sample_we),
        .i_sample       (i_sample),
        .i_weight       (i_weight),
        .o_cmd_rd_en    (o_cmd_rd_en),
        .o_data_addr    (o_data_addr),
        .o_weight_addr  (o_weight_addr),
        .o_result       (o_result),
        .o_result_valid (o_result_valid),
        .o_irq          (o_irq)
    );

    initial clk = 1'b0;
    always #(CLK_HALF) clk = ~clk;

    function automatic logic [15:0] rand16();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return lcg_state[30:15];
    endfunction

    function automatic int rand_base();
        return int'(rand16()) % (SAT_BASE - 16);
    endfunction

    function automatic logic [7:0] pick_kernel();
        case (rand16() % 3)
            0: return 8'd1;
            1: return 8'd2;
            default: return 8'd4;
        endcase
    endfunction

    function automatic cnn_pkg::op_e pick_op();
        case (rand16() % 4)
            0: return cnn_pkg::OP_IDLE;
            1: return cnn_pkg::OP_CONV_RELU;
            2: return cnn_pkg::OP_MAX_POOL;
            default: return cnn_pkg::OP_AVG_POOL;
        endcase
    endfunction

    // Uninterpreted fields get random filler
    function automatic cnn_pkg::layer_cmd_t make_cmd(input cnn_pkg::op_e op,
            input logic [7:0] kernel, input int data_base, input int weight_base);
        cnn_pkg::layer_cmd_t c;
        logic [15:0]         r;
        r = rand16();
        c.op          = op;
        c.padding     = r[0];
        c.stride      = r[4:1];
        c.kernel      = kernel;
        c.in_channel  = rand16();
        c.out_channel = rand16();
        r = rand16();
        c.in_side     = r[7:0];
        c.out_side    = r[15:8];
        c.weight_addr = 32'(weight_base);
        c.data_addr   = 32'(data_base);
        c.result_addr = {rand16(), rand16()};
        return c;
    endfunction

    // FIFO word layout, word 0 first
    function automatic logic [`CNN_WORD_W-1:0] pack_word(input cnn_pkg::layer_cmd_t c,
            input int idx);
        logic [`CNN_WORD_W-1:0] w;
        w = '0;
        case (idx)
            0: begin
                w[2:0]   = c.op;
                w[4]     = c.padding;
                w[11:8]  = c.stride;
                w[23:16] = c.kernel;
            end
            1: w = {c.out_channel, c.in_channel};
            2: w[15:0] = {c.out_side, c.in_side};
            3: w = c.weight_addr;
            4: w = c.data_addr;
            default: w = c.result_addr;
        endcase
        return w;
    endfunction

    // Expected output of one command from the memory contents
    function automatic cnn_pkg::layer_result_t ref_result(input cnn_pkg::layer_cmd_t c,
            input logic signed [7:0] smem [MEM_DEPTH], input logic signed [7:0] wmem [MEM_DEPTH]);
        cnn_pkg::layer_result_t r;
        int n;
        int i;
        int s;
        int w;
        int sum;
        int mx;
        int val;
        int kk;
        int shift;
        n   = int'(c.kernel) * int'(c.kernel);
        sum = 0;
        mx  = 0;
        for (i = 0; i < n; i++) begin
            s = smem[int'(c.data_addr) + i];
            w = wmem[int'(c.weight_addr) + i];
            if (c.op == cnn_pkg::OP_CONV_RELU) begin
                sum = sum + s * w;
            end else begin
                sum = sum + s;
            end
            if (i == 0 || s > mx) begin
                mx = s;
            end
        end
        // Average divides by kernel squared, a power of four here
        shift = 0;
        kk    = int'(c.kernel);
        while (kk > 1) begin
            kk    = kk / 2;
            shift = shift + 2;
        end
        case (c.op)
            cnn_pkg::OP_CONV_RELU: val = (sum < 0) ? 0 : sum;
            cnn_pkg::OP_MAX_POOL:  val = mx;
            default:               val = sum >>> shift;
        endcase
        if (val > 32767) begin
            val = 32767;
        end else if (val < -32768) begin
            val = -32768;
        end
        r.value = val[15:0];
        r.addr  = c.result_addr;
        return r;
    endfunction

    task automatic check_result(input cnn_pkg::layer_result_t exp,
            input cnn_pkg::layer_result_t act);
        check_cnt++;
        if (act !== exp) begin
            mismatch_cnt++;
            $display("Mismatch at %0t ns: result expected value %0d addr %h, got value %0d addr %h",
                $time, exp.value, exp.addr, act.value, act.addr);
        end
    endtask

    task automatic check_irq(input bit exp, input bit act);
        check_cnt++;
        if (act !== exp) begin
            mismatch_cnt++;
            $display("Mismatch at %0t ns: irq expected %0b, got %0b", $time, exp, act);
        end
    endtask

    task automatic check_addr(input logic [`CNN_ADDR_W-1:0] exp,
            input logic [`CNN_ADDR_W-1:0] act, input string what);
        check_cnt++;
        if (act !== exp) begin
            mismatch_cnt++;
            $display("Mismatch at %0t ns: %s address expected %h, got %h",
                $time, what, exp, act);
        end
    endtask

    task automatic apply_reset();
        rst         = 1'b1;
        i_op_en     = 1'b0;
        i_cmd_we    = 1'b0;
        i_sample_we = 1'b0;
        repeat (5) @(negedge clk);
        rst = 1'b0;
    endtask

    task automatic fill_memories();
        int          a;
        logic [15:0] r;
        for (a = 0; a < MEM_DEPTH; a++) begin
            r = rand16();
            sample_mem[a] = r[7:0];
            weight_mem[a] = r[15:8];
        end
        // Full-scale window drives the convolution into saturation
        for (a = SAT_BASE; a < SAT_BASE + 16; a++) begin
            sample_mem[a] = 8'sd127;
            weight_mem[a] = 8'sd127;
        end
        // Window of negative samples only
        for (a = NEG_BASE; a < NEG_BASE + 16; a++) begin
            r = rand16();
            sample_mem[a] = {1'b1, r[6:0]};
        end
    endtask

    // Feeds six words while the read level is up, with random gaps
    task automatic load_cmd(input cnn_pkg::layer_cmd_t c);
        int w;
        w = 0;
        while (w < `CNN_CMD_WORDS) begin
            @(negedge clk);
            if (o_cmd_rd_en && (rand16() % 4) != 0) begin
                i_cmd_we = 1'b1;
                i_cmd    = pack_word(c, w);
                w++;
            end else begin
                i_cmd_we = 1'b0;
            end
        end
        @(negedge clk);
        i_cmd_we = 1'b0;
    endtask

    // Answers the window addresses, holding the strobe low at random
    task automatic run_window(input cnn_pkg::layer_cmd_t c);
        int n;
        int i;
        n = int'(c.kernel) * int'(c.kernel);
        // Issue then the engine start edge before the window is open
        repeat (2) @(negedge clk);
        for (i = 0; i < n; i++) begin
            if ((rand16() % 4) == 0) begin
                i_sample_we = 1'b0;
                @(negedge clk);
            end
            // Both address levels step with each accepted sample
            check_addr(c.data_addr + 32'(i), o_data_addr, "data");
            check_addr(c.weight_addr + 32'(i), o_weight_addr, "weight");
            if (o_data_addr >= MEM_DEPTH || o_weight_addr >= MEM_DEPTH) begin
                error_cnt++;
                $display("Error at %0t ns: window address outside the sample memory", $time);
                i_sample = '0;
                i_weight = '0;
            end else begin
                i_sample = sample_mem[int'(o_data_addr)];
                i_weight = weight_mem[int'(o_weight_addr)];
            end
            i_sample_we = 1'b1;
            @(negedge clk);
        end
        i_sample_we = 1'b0;
    endtask

    task automatic run_layer();
        int                  j;
        int                  waited;
        cnn_pkg::layer_cmd_t c;
        // Stray FIFO strobes before the enable must be ignored
        repeat (4) begin
            @(negedge clk);
            i_cmd_we = 1'b1;
            i_cmd    = {rand16(), rand16()};
            if (o_cmd_rd_en || o_result_valid) begin
                error_cnt++;
                $display("Error at %0t ns: layer activity before enable", $time);
            end
            check_irq(1'b0, o_irq);
        end
        i_cmd_we    = 1'b0;
        i_cmd_count = `CNN_CMD_CNT_W'(layer_q.size());
        i_op_en     = 1'b1;
        for (j = 0; j < layer_q.size(); j++) begin
            c = layer_q[j];
            if (c.op != cnn_pkg::OP_IDLE) begin
                exp_q.push_back(ref_result(c, sample_mem, weight_mem));
                exp_last_q.push_back(j == layer_q.size() - 1);
            end
            load_cmd(c);
            if (c.op != cnn_pkg::OP_IDLE) begin
                run_window(c);
            end
        end
        waited = 0;
        while (!o_irq && waited < 20) begin
            @(negedge clk);
            waited++;
        end
        if (!o_irq) begin
            error_cnt++;
            $display("Error at %0t ns: interrupt did not rise after the last command", $time);
        end
        @(negedge clk);
        if (exp_q.size() != 0) begin
            error_cnt++;
            $display("Error at %0t ns: %0d results never arrived", $time, exp_q.size());
            exp_q.delete();
            exp_last_q.delete();
        end
        // Interrupt holds until reset
        repeat (3) begin
            @(negedge clk);
            check_irq(1'b1, o_irq);
        end
    endtask

    // Result checker, samples between edges
    always @(negedge clk) begin
        if (!rst && o_result_valid) begin
            if (exp_q.size() == 0) begin
                error_cnt++;
                $display("Error at %0t ns: result pulse with no command expecting one", $time);
            end else begin
                check_result(exp_q.pop_front(), o_result);
                check_irq(exp_last_q.pop_front(), o_irq);
            end
        end
    end

    initial begin
        #((DIR_CMDS + RAND_CMDS) * CMD_CYCLES * 2 * CLK_HALF + SLACK_CYCLES * 2 * CLK_HALF);
        $display("Timeout: layers did not finish in time, checks %0d mismatches %0d errors %0d",
            check_cnt, mismatch_cnt, error_cnt);
        $display("Simulation failed");
        $finish;
    end

    initial begin
        int j;
        lcg_state    = 32'd27619;
        check_cnt    = 0;
        mismatch_cnt = 0;
        error_cnt    = 0;
        rst          = 1'b1;
        i_op_en      = 1'b0;
        i_cmd_we     = 1'b0;
        i_cmd        = '0;
        i_cmd_count  = '0;
        i_sample_we  = 1'b0;
        i_sample     = '0;
        i_weight     = '0;
        fill_memories();
        apply_reset();
        // Directed layer, ends on a no-op so completion relies on the idle retire
        layer_q.push_back(make_cmd(cnn_pkg::OP_CONV_RELU, 8'd4, rand_base(), rand_base()));
        layer_q.push_back(make_cmd(cnn_pkg::OP_CONV_RELU, 8'd4, SAT_BASE, SAT_BASE));
        layer_q.push_back(make_cmd(cnn_pkg::OP_CONV_RELU, 8'd2, NEG_BASE, SAT_BASE));
        layer_q.push_back(make_cmd(cnn_pkg::OP_MAX_POOL, 8'd4, NEG_BASE, rand_base()));
        layer_q.push_back(make_cmd(cnn_pkg::OP_MAX_POOL, 8'd2, rand_base(), rand_base()));
        layer_q.push_back(make_cmd(cnn_pkg::OP_AVG_POOL, 8'd1, rand_base(), rand_base()));
        layer_q.push_back(make_cmd(cnn_pkg::OP_AVG_POOL, 8'd2, rand_base(), rand_base()));
        layer_q.push_back(make_cmd(cnn_pkg::OP_AVG_POOL, 8'd4, SAT_BASE, rand_base()));
        layer_q.push_back(make_cmd(cnn_pkg::OP_IDLE, 8'd2, rand_base(), rand_base()));
        run_layer();
        // Mixed random layer after a fresh reset
        apply_reset();
        layer_q.delete();
        for (j = 0; j < RAND_CMDS; j++) begin
            layer_q.push_back(make_cmd(pick_op(), pick_kernel(), rand_base(), rand_base()));
        end
        run_layer();
        $display("Checks %0d, mismatches %0d, other errors %0d",
            check_cnt, mismatch_cnt, error_cnt);
        if (mismatch_cnt == 0 && error_cnt == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

// ==== cnn_layer.f ====
+incdir+rtl
rtl/cnn_pkg.sv
rtl/cmd_decode.sv
rtl/window_engine.sv
rtl/result_writer.sv
rtl/cnn_layer_top.sv
sim/tb_cnn_layer.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build the cnn_layer testbench with Verilator and run it
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --top-module tb_cnn_layer -f cnn_layer.f
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

output=$(./obj_dir/Vtb_cnn_layer)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
    echo "Simulation executable returned status $status"
    exit 1
fi

if echo "$output" | grep -q "Simulation completed successfully"; then
    exit 0
fi
echo "Pass message not found in simulation output"
exit 1
